//--- simmem_resp_bank.f
+incdir+tb
src/simmem_resp_pkg.sv
src/simmem_resp_slot_table.sv
src/simmem_resp_id_queue.sv
src/simmem_resp_release_arbiter.sv
src/simmem_resp_bank.sv
tb/simmem_resp_bank_tb.sv

//--- Bender.yml
package:
  name: simmem_resp_bank

sources:
  - src/simmem_resp_pkg.sv
  - src/simmem_resp_slot_table.sv
  - src/simmem_resp_id_queue.sv
  - src/simmem_resp_release_arbiter.sv
  - src/simmem_resp_bank.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/simmem_resp_bank_tb.sv

//--- tb/simmem_resp_bank_model.svh
/*
  Cycle model of the bank, included inside the testbench module.
  A slot counts as used from its reservation until its output is accepted.
  Each queue is a ring of slot addresses in reservation order.
*/

`ifndef SIMMEM_RESP_BANK_MODEL_SVH
`define SIMMEM_RESP_BANK_MODEL_SVH

simmem_resp_pkg::slot_mask_t m_used;
simmem_resp_pkg::slot_addr_t m_ring [simmem_resp_pkg::NumIds][simmem_resp_pkg::NumSlots];
int m_rd [simmem_resp_pkg::NumIds];
int m_len [simmem_resp_pkg::NumIds];
int m_filled [simmem_resp_pkg::NumIds];
simmem_resp_pkg::msg_t m_data [simmem_resp_pkg::NumSlots];

// Output register as the bank should hold it
logic m_out_valid;
simmem_resp_pkg::slot_addr_t m_out_addr;
simmem_resp_pkg::msg_t m_out_data;

int error_count;
int check_count;

function automatic void model_reset();
  m_used = '0;
  m_out_valid = 1'b0;
  for (int i = 0; i < simmem_resp_pkg::NumIds; i++) begin
    m_rd[i] = 0;
    m_len[i] = 0;
    m_filled[i] = 0;
  end
endfunction

// Slot at position pos of a queue, 0 is the oldest
function automatic simmem_resp_pkg::slot_addr_t entry(input int id, input int pos);
  return m_ring[id][(m_rd[id] + pos) % simmem_resp_pkg::NumSlots];
endfunction

function automatic simmem_resp_pkg::slot_addr_t lowest_free();
  for (int i = 0; i < simmem_resp_pkg::NumSlots; i++) begin
    if (!m_used[i]) begin
      return simmem_resp_pkg::slot_addr_t'(i);
    end
  end
  return '0;
endfunction

function automatic int unfilled(input int id);
  return m_len[id] - m_filled[id];
endfunction

function automatic logic head_ready(input int id, input simmem_resp_pkg::slot_mask_t ren);
  return (m_filled[id] > 0) && ren[entry(id, 0)];
endfunction

// Advance the model by one clock edge with the inputs of the ending cycle
task automatic model_step(input logic rsv_rdy, input simmem_resp_pkg::id_t rid,
                          input logic in_vld, input simmem_resp_pkg::msg_t idata,
                          input simmem_resp_pkg::slot_mask_t ren, input logic ordy);
  logic rsv_fire;
  logic fill_fire;
  logic can_load;
  logic found;
  int in_id;
  int sel;
  simmem_resp_pkg::slot_addr_t rsv_slot;
  simmem_resp_pkg::slot_addr_t fill_slot;
  rsv_fire = rsv_rdy && (m_used != '1);
  rsv_slot = lowest_free();
  in_id = int'(idata[simmem_resp_pkg::IdWidth-1:0]);
  fill_fire = in_vld && (unfilled(in_id) > 0);
  fill_slot = entry(in_id, m_filled[in_id]);
  can_load = !m_out_valid || ordy;
  found = 1'b0;
  sel = 0;
  for (int i = 0; i < simmem_resp_pkg::NumIds; i++) begin
    if (!found && head_ready(i, ren)) begin
      found = 1'b1;
      sel = i;
    end
  end
  // Freed slot becomes reservable from the next cycle on
  if (m_out_valid && ordy) begin
    m_used[m_out_addr] = 1'b0;
  end
  if (fill_fire) begin
    m_data[fill_slot] = idata;
  end
  if (can_load) begin
    m_out_valid = found;
    if (found) begin
      m_out_addr = entry(sel, 0);
      m_out_data = m_data[m_out_addr];
      m_rd[sel] = (m_rd[sel] + 1) % simmem_resp_pkg::NumSlots;
      m_len[sel]--;
      m_filled[sel]--;
    end
  end
  if (fill_fire) begin
    m_filled[in_id]++;
  end
  if (rsv_fire) begin
    m_used[rsv_slot] = 1'b1;
    m_ring[rid][(m_rd[rid] + m_len[rid]) % simmem_resp_pkg::NumSlots] = rsv_slot;
    m_len[rid]++;
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_addr(input string name, input simmem_resp_pkg::slot_addr_t exp,
                          input simmem_resp_pkg::slot_addr_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("** Error %s: expected %0h, actual %0h", name, exp, act);
  end
endtask

task automatic check_msg(input string name, input simmem_resp_pkg::msg_t exp,
                         input simmem_resp_pkg::msg_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("** Error %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_mask(input string name, input simmem_resp_pkg::slot_mask_t exp,
                          input simmem_resp_pkg::slot_mask_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("** Error %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("** Error %s: expected %b, actual %b", name, exp, act);
  end
endtask

`endif

//--- tb/simmem_resp_bank_tb.sv
/*
  Testbench of the write-response bank against a cycle model.
  Inputs change on the rising edge, outputs are compared on the falling edge.
  Random phase first, then a directed priority check, each followed by a drain.
*/

module simmem_resp_bank_tb;

  localparam int RandCycles = 800;
  localparam int DrainMax = 200;
  localparam int DirectedCycles = 20;
  localparam int CycleLimit = 2 * (16 + RandCycles + 2 * DrainMax + DirectedCycles);

  logic clk_i;
  logic rst_ni;
  simmem_resp_pkg::id_t rsv_id;
  logic rsv_ready;
  logic rsv_valid;
  simmem_resp_pkg::slot_addr_t rsv_addr;
  logic in_valid;
  simmem_resp_pkg::msg_t in_data;
  logic in_ready;
  simmem_resp_pkg::slot_mask_t release_en;
  logic out_ready;
  logic out_valid;
  simmem_resp_pkg::msg_t data;
  simmem_resp_pkg::slot_mask_t released;

  logic [31:0] rand_state;
  int cycle_count;
  logic saw_full;
  logic held_prev;
  simmem_resp_pkg::msg_t data_prev;

  `include "simmem_resp_bank_model.svh"

  simmem_resp_bank dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rsv_id_i          (rsv_id),
    .rsv_ready_i       (rsv_ready),
    .rsv_valid_o       (rsv_valid),
    .rsv_addr_o        (rsv_addr),
    .in_valid_i        (in_valid),
    .in_data_i         (in_data),
    .in_ready_o        (in_ready),
    .release_en_i      (release_en),
    .out_ready_i       (out_ready),
    .out_valid_o       (out_valid),
    .data_o            (data),
    .released_onehot_o (released)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("Run stopped after %0d cycles without finishing", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state[31:16];
  endfunction

  task automatic check_outputs();
    int in_id;
    simmem_resp_pkg::slot_mask_t exp_rel;
    in_id = int'(in_data[simmem_resp_pkg::IdWidth-1:0]);
    exp_rel = '0;
    if (m_out_valid && out_ready) begin
      exp_rel[m_out_addr] = 1'b1;
    end
    check_bit("rsv_valid", m_used != '1, rsv_valid);
    if (m_used != '1) begin
      check_addr("rsv_addr", lowest_free(), rsv_addr);
    end else begin
      saw_full = 1'b1;
    end
    check_bit("in_ready", unfilled(in_id) > 0, in_ready);
    check_bit("out_valid", m_out_valid, out_valid);
    if (m_out_valid) begin
      check_msg("data", m_out_data, data);
    end
    check_mask("released_onehot", exp_rel, released);
    // Held output must not move under back-pressure
    if (held_prev) begin
      check_msg("data_stable", data_prev, data);
    end
    held_prev = m_out_valid && !out_ready;
    data_prev = m_out_data;
  endtask

  task automatic step_cycle(input logic rsv_rdy, input simmem_resp_pkg::id_t rid,
                            input logic in_vld, input simmem_resp_pkg::msg_t idata,
                            input simmem_resp_pkg::slot_mask_t ren, input logic ordy);
    @(posedge clk_i);
    model_step(rsv_ready, rsv_id, in_valid, in_data, release_en, out_ready);
    rsv_ready <= rsv_rdy;
    rsv_id <= rid;
    in_valid <= in_vld;
    in_data <= idata;
    release_en <= ren;
    out_ready <= ordy;
    @(negedge clk_i);
    check_outputs();
  endtask

  // Fill all reserved slots and release everything until the pool is empty
  task automatic drain();
    int id;
    simmem_resp_pkg::msg_t msg;
    for (int n = 0; n < DrainMax; n++) begin
      id = 0;
      for (int i = simmem_resp_pkg::NumIds - 1; i >= 0; i--) begin
        if (unfilled(i) > 0) begin
          id = i;
        end
      end
      msg = next_rand();
      msg[simmem_resp_pkg::IdWidth-1:0] = simmem_resp_pkg::id_t'(id);
      step_cycle(1'b0, '0, unfilled(id) > 0, msg, '1, 1'b1);
      if (n > 0 && m_used == '0) begin
        return;
      end
    end
    error_count++;
    $display("Bank still holds slots after %0d drain cycles", DrainMax);
  endtask

  initial begin
    logic [15:0] r;
    simmem_resp_pkg::slot_mask_t ren;
    simmem_resp_pkg::msg_t msg;
    simmem_resp_pkg::msg_t first_msg;
    int waited;
    rand_state = 32'd91594;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    saw_full = 1'b0;
    held_prev = 1'b0;
    data_prev = '0;
    first_msg = '0;
    rst_ni = 1'b0;
    rsv_id = '0;
    rsv_ready = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    release_en = '0;
    out_ready = 1'b0;
    model_reset();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("reset_rsv_valid", 1'b1, rsv_valid);
    check_addr("reset_rsv_addr", '0, rsv_addr);
    check_bit("reset_in_ready", 1'b0, in_ready);
    check_bit("reset_out_valid", 1'b0, out_valid);
    check_mask("reset_released", '0, released);

    //////////////////////////////////////////////////////////////////////////
    // Random traffic with sparse release enables first so the pool fills up
    //////////////////////////////////////////////////////////////////////////
    for (int n = 0; n < RandCycles; n++) begin
      r = next_rand();
      ren = next_rand();
      if (n < RandCycles / 2) begin
        ren = ren & next_rand() & next_rand();
      end else begin
        ren = ren | next_rand();
      end
      msg = next_rand();
      step_cycle(r[0] | r[1], simmem_resp_pkg::id_t'(r[3:2]), r[4] | r[5], msg, ren,
                 r[6] | r[7]);
    end
    drain();

    //////////////////////////////////////////////////////////////////////////
    // Directed priority check with the highest identifier reserved first
    //////////////////////////////////////////////////////////////////////////
    for (int i = simmem_resp_pkg::NumIds - 1; i >= 1; i--) begin
      step_cycle(1'b1, simmem_resp_pkg::id_t'(i), 1'b0, '0, '0, 1'b1);
    end
    for (int i = simmem_resp_pkg::NumIds - 1; i >= 1; i--) begin
      msg = next_rand();
      msg[simmem_resp_pkg::IdWidth-1:0] = simmem_resp_pkg::id_t'(i);
      if (i == 1) begin
        first_msg = msg;
      end
      step_cycle(1'b0, '0, 1'b1, msg, '0, 1'b1);
    end
    repeat (4) step_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1);
    step_cycle(1'b0, '0, 1'b0, '0, '1, 1'b1);
    waited = 0;
    while (!out_valid && waited < 8) begin
      step_cycle(1'b0, '0, 1'b0, '0, '1, 1'b1);
      waited++;
    end
    check_bit("first_release_valid", 1'b1, out_valid);
    if (out_valid) begin
      check_msg("first_release", first_msg, data);
    end
    drain();

    if (!saw_full) begin
      error_count++;
      $display("The slot pool never became full during random traffic");
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src/simmem_resp_bank.sv
/*
  Write-response bank with one queue per identifier over a shared slot
  pool. A client reserves a slot before the message arrives. Messages
  leave in reservation order per identifier, gated by release_en_i.
*/

module simmem_resp_bank (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Reservation
  input  simmem_resp_pkg::id_t        rsv_id_i,
  input  logic                        rsv_ready_i,
  output logic                        rsv_valid_o,
  output simmem_resp_pkg::slot_addr_t rsv_addr_o,

  // Message input
  input  logic                        in_valid_i,
  input  simmem_resp_pkg::msg_t       in_data_i,
  output logic                        in_ready_o,

  // Release and output
  input  simmem_resp_pkg::slot_mask_t release_en_i,
  input  logic                        out_ready_i,
  output logic                        out_valid_o,
  output simmem_resp_pkg::msg_t       data_o,
  output simmem_resp_pkg::slot_mask_t released_onehot_o
);

  simmem_resp_pkg::id_t in_id;
  logic fill_fire;

  // Slot table side
  logic rsv_fire;
  simmem_resp_pkg::id_t rsv_id;
  simmem_resp_pkg::slot_addr_t lookup_addr [simmem_resp_pkg::NumIds][2];
  simmem_resp_pkg::slot_addr_t lookup_next [simmem_resp_pkg::NumIds][2];
  simmem_resp_pkg::slot_addr_t read_addr;
  simmem_resp_pkg::msg_t read_data;
  logic free_en;
  simmem_resp_pkg::slot_addr_t free_addr;

  // Per-queue signals
  simmem_resp_pkg::id_mask_t fill_ready;
  simmem_resp_pkg::id_mask_t link_en;
  simmem_resp_pkg::id_mask_t eligible;
  simmem_resp_pkg::id_mask_t pop;
  simmem_resp_pkg::slot_addr_t fill_addr [simmem_resp_pkg::NumIds];
  simmem_resp_pkg::slot_addr_t tail [simmem_resp_pkg::NumIds];
  simmem_resp_pkg::slot_addr_t head_addr [simmem_resp_pkg::NumIds];

  // Identifier field of the incoming message
  assign in_id = in_data_i[simmem_resp_pkg::IdWidth-1:0];
  assign in_ready_o = fill_ready[in_id];
  assign fill_fire = in_valid_i && in_ready_o;

  simmem_resp_slot_table i_slot_table (
    .clk_i,
    .rst_ni,
    .rsv_ready_i,
    .rsv_id_i,
    .rsv_valid_o,
    .rsv_addr_o,
    .rsv_fire_o    (rsv_fire),
    .rsv_id_o      (rsv_id),
    .fill_en_i     (fill_fire),
    .fill_addr_i   (fill_addr[in_id]),
    .fill_data_i   (in_data_i),
    .link_en_i     (|link_en),
    .link_from_i   (tail[rsv_id]),
    .lookup_addr_i (lookup_addr),
    .lookup_next_o (lookup_next),
    .read_addr_i   (read_addr),
    .read_data_o   (read_data),
    .free_en_i     (free_en),
    .free_addr_i   (free_addr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Identifier queues
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < simmem_resp_pkg::NumIds; g++) begin : gen_queues
    assign lookup_addr[g][0] = fill_addr[g];
    assign lookup_addr[g][1] = head_addr[g];

    simmem_resp_id_queue i_queue (
      .clk_i,
      .rst_ni,
      .rsv_fire_i      (rsv_fire),
      // Zero when the reservation targets queue g
      .rsv_id_i        (rsv_id ^ simmem_resp_pkg::id_t'(g)),
      .rsv_addr_i      (rsv_addr_o),
      .fill_i          (fill_fire && (in_id == simmem_resp_pkg::id_t'(g))),
      .fill_ready_o    (fill_ready[g]),
      .fill_addr_o     (fill_addr[g]),
      .fill_next_i     (lookup_next[g][0]),
      .link_en_o       (link_en[g]),
      .tail_o          (tail[g]),
      .head_next_i     (lookup_next[g][1]),
      .pop_i           (pop[g]),
      .release_en_i,
      .head_eligible_o (eligible[g]),
      .head_addr_o     (head_addr[g])
    );
  end

  simmem_resp_release_arbiter i_arbiter (
    .clk_i,
    .rst_ni,
    .eligible_i        (eligible),
    .head_addr_i       (head_addr),
    .pop_o             (pop),
    .read_addr_o       (read_addr),
    .read_data_i       (read_data),
    .free_en_o         (free_en),
    .free_addr_o       (free_addr),
    .out_ready_i,
    .out_valid_o,
    .data_o,
    .released_onehot_o
  );

endmodule

//--- src/simmem_resp_release_arbiter.sv
/*
  Lowest-identifier release of eligible queue heads into a one-entry
  output register. The popped slot stays used until the output is
  accepted. The payload read from the slot table must be valid in the
  cycle of selection.
*/

module simmem_resp_release_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Queue heads
  input  simmem_resp_pkg::id_mask_t   eligible_i,
  input  simmem_resp_pkg::slot_addr_t head_addr_i [simmem_resp_pkg::NumIds],
  output simmem_resp_pkg::id_mask_t   pop_o,

  // Slot table access
  output simmem_resp_pkg::slot_addr_t read_addr_o,
  input  simmem_resp_pkg::msg_t       read_data_i,
  output logic                        free_en_o,
  output simmem_resp_pkg::slot_addr_t free_addr_o,

  // Output register
  input  logic                        out_ready_i,
  output logic                        out_valid_o,
  output simmem_resp_pkg::msg_t       data_o,
  output simmem_resp_pkg::slot_mask_t released_onehot_o
);

  simmem_resp_pkg::id_t sel_id;
  simmem_resp_pkg::id_mask_t sel_onehot;
  logic accept;
  logic can_load;

  logic valid_q;
  simmem_resp_pkg::msg_t data_q;
  simmem_resp_pkg::slot_addr_t addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Selection
  ////////////////////////////////////////////////////////////////////////////

  // Lowest eligible identifier wins
  always_comb begin
    sel_id = '0;
    sel_onehot = '0;
    for (int i = simmem_resp_pkg::NumIds - 1; i >= 0; i--) begin
      if (eligible_i[i]) begin
        sel_id = simmem_resp_pkg::id_t'(i);
        sel_onehot = simmem_resp_pkg::id_mask_t'(1) << i;
      end
    end
  end

  assign accept = valid_q && out_ready_i;
  // Register empty or emptied this cycle
  assign can_load = !valid_q || out_ready_i;

  assign pop_o = can_load ? sel_onehot : '0;
  assign read_addr_o = head_addr_i[sel_id];

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (can_load) begin
      valid_q <= |eligible_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (can_load && |eligible_i) begin
      data_q <= read_data_i;
      addr_q <= read_addr_o;
    end
  end

  assign out_valid_o = valid_q;
  assign data_o = data_q;

  // Slot goes back to the pool on acceptance
  assign free_en_o = accept;
  assign free_addr_o = addr_q;
  assign released_onehot_o = accept ? (simmem_resp_pkg::slot_mask_t'(1) << addr_q) : '0;

  // Held message and slot stay put until accepted
  a_stable_under_backpressure: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_q && !out_ready_i |=> valid_q && $stable(data_q) && $stable(addr_q));

endmodule

//--- src/simmem_resp_id_queue.sv
/*
  One linked-list queue of slots for a single identifier.
  rsv_id_i is relative to this queue and is zero when a reservation
  targets it. Pointers are only meaningful while the matching count is
  nonzero.
*/

module simmem_resp_id_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Reservation broadcast from the slot table
  input  logic                        rsv_fire_i,
  input  simmem_resp_pkg::id_t        rsv_id_i,
  input  simmem_resp_pkg::slot_addr_t rsv_addr_i,

  // Fill of the oldest unfilled slot
  input  logic                        fill_i,
  output logic                        fill_ready_o,
  output simmem_resp_pkg::slot_addr_t fill_addr_o,
  input  simmem_resp_pkg::slot_addr_t fill_next_i,

  // Link write request for the slot table
  output logic                        link_en_o,
  output simmem_resp_pkg::slot_addr_t tail_o,

  // Head towards the arbiter
  input  simmem_resp_pkg::slot_addr_t head_next_i,
  input  logic                        pop_i,
  input  simmem_resp_pkg::slot_mask_t release_en_i,
  output logic                        head_eligible_o,
  output simmem_resp_pkg::slot_addr_t head_addr_o
);

  simmem_resp_pkg::slot_addr_t head_d, head_q;
  simmem_resp_pkg::slot_addr_t fill_d, fill_q;
  simmem_resp_pkg::slot_addr_t tail_d, tail_q;

  // Reserved but unfilled, and filled but not popped
  simmem_resp_pkg::count_t rsv_cnt_d, rsv_cnt_q;
  simmem_resp_pkg::count_t filled_cnt_d, filled_cnt_q;

  simmem_resp_pkg::count_t total;
  simmem_resp_pkg::count_t total_after_pop;
  simmem_resp_pkg::count_t rsv_after_fill;
  logic rsv_here;

  assign rsv_here = rsv_fire_i && (rsv_id_i == '0);

  assign total = rsv_cnt_q + filled_cnt_q;
  assign total_after_pop = total - simmem_resp_pkg::count_t'(pop_i);
  assign rsv_after_fill = rsv_cnt_q - simmem_resp_pkg::count_t'(fill_i);

  ////////////////////////////////////////////////////////////////////////////
  // Counts and pointers
  ////////////////////////////////////////////////////////////////////////////

  assign rsv_cnt_d = rsv_after_fill + simmem_resp_pkg::count_t'(rsv_here);
  assign filled_cnt_d = filled_cnt_q + simmem_resp_pkg::count_t'(fill_i)
      - simmem_resp_pkg::count_t'(pop_i);

  always_comb begin
    head_d = head_q;
    fill_d = fill_q;
    tail_d = tail_q;

    // Links behind the head and fill pointer were written at earlier edges
    if (pop_i) begin
      head_d = head_next_i;
    end
    if (fill_i) begin
      fill_d = fill_next_i;
    end

    if (rsv_here) begin
      tail_d = rsv_addr_i;
      // Queue empty after this cycle, seed the head
      if (total_after_pop == '0) begin
        head_d = rsv_addr_i;
      end
      // No unfilled slot left, the new one is the next to fill
      if (rsv_after_fill == '0) begin
        fill_d = rsv_addr_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '0;
      fill_q <= '0;
      tail_q <= '0;
      rsv_cnt_q <= '0;
      filled_cnt_q <= '0;
    end else begin
      head_q <= head_d;
      fill_q <= fill_d;
      tail_q <= tail_d;
      rsv_cnt_q <= rsv_cnt_d;
      filled_cnt_q <= filled_cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign fill_ready_o = rsv_cnt_q != '0;
  assign fill_addr_o = fill_q;

  // Append behind the current tail when the queue holds anything
  assign link_en_o = rsv_here && (total != '0);
  assign tail_o = tail_q;

  assign head_eligible_o = (filled_cnt_q != '0) && release_en_i[head_q];
  assign head_addr_o = head_q;

  // The pool bounds the sum of both counts
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsv_here |-> total < simmem_resp_pkg::count_t'(simmem_resp_pkg::NumSlots));

  // Fill and pop only arrive for slots this queue owns
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (fill_i |-> rsv_cnt_q != '0) and (pop_i |-> filled_cnt_q != '0));

endmodule

//--- src/simmem_resp_slot_table.sv
/*
  Slot pool of the bank. Links and payloads are flip-flop arrays, read
  combinationally. Only one link write per cycle is supported, which holds
  because only one reservation happens per cycle.
*/

module simmem_resp_slot_table (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Reservation
  input  logic                        rsv_ready_i,
  input  simmem_resp_pkg::id_t        rsv_id_i,
  output logic                        rsv_valid_o,
  output simmem_resp_pkg::slot_addr_t rsv_addr_o,
  output logic                        rsv_fire_o,
  output simmem_resp_pkg::id_t        rsv_id_o,

  // Payload write on fill
  input  logic                        fill_en_i,
  input  simmem_resp_pkg::slot_addr_t fill_addr_i,
  input  simmem_resp_pkg::msg_t       fill_data_i,

  // Link from the old tail to the newly reserved slot
  input  logic                        link_en_i,
  input  simmem_resp_pkg::slot_addr_t link_from_i,

  // Port 0 follows the fill pointer, port 1 the head
  input  simmem_resp_pkg::slot_addr_t lookup_addr_i [simmem_resp_pkg::NumIds][2],
  output simmem_resp_pkg::slot_addr_t lookup_next_o [simmem_resp_pkg::NumIds][2],

  // Payload read and slot free on release
  input  simmem_resp_pkg::slot_addr_t read_addr_i,
  output simmem_resp_pkg::msg_t       read_data_o,
  input  logic                        free_en_i,
  input  simmem_resp_pkg::slot_addr_t free_addr_i
);

  simmem_resp_pkg::slot_mask_t used_d;
  simmem_resp_pkg::slot_mask_t used_q;

  simmem_resp_pkg::slot_addr_t link_q [simmem_resp_pkg::NumSlots];
  simmem_resp_pkg::msg_t payload_q [simmem_resp_pkg::NumSlots];

  ////////////////////////////////////////////////////////////////////////////
  // Free bitmap and lowest free slot
  ////////////////////////////////////////////////////////////////////////////

  assign rsv_valid_o = |(~used_q);
  assign rsv_fire_o = rsv_valid_o && rsv_ready_i;
  assign rsv_id_o = rsv_id_i;

  // Priority chain, the lowest free address wins
  always_comb begin
    rsv_addr_o = '0;
    for (int i = simmem_resp_pkg::NumSlots - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        rsv_addr_o = simmem_resp_pkg::slot_addr_t'(i);
      end
    end
  end

  always_comb begin
    used_d = used_q;
    if (rsv_fire_o) begin
      used_d[rsv_addr_o] = 1'b1;
    end
    // The freed slot is still used this cycle, so it never equals rsv_addr_o
    if (free_en_i) begin
      used_d[free_addr_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Links and payloads
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      payload_q[fill_addr_i] <= fill_data_i;
    end
    if (link_en_i) begin
      link_q[link_from_i] <= rsv_addr_o;
    end
  end

  always_comb begin
    for (int id = 0; id < simmem_resp_pkg::NumIds; id++) begin
      for (int port = 0; port < 2; port++) begin
        lookup_next_o[id][port] = link_q[lookup_addr_i[id][port]];
      end
    end
  end

  assign read_data_o = payload_q[read_addr_i];

  // The arbiter only frees what a queue once reserved
  a_free_used_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
      free_en_i |-> used_q[free_addr_i]);

endmodule

//--- src/simmem_resp_pkg.sv
/*
  Shared widths and vector types of the write-response bank.
  The identifier is the low IdWidth bits of a message. NumSlots must be a
  power of two, and count_t must hold the value NumSlots.
*/

package simmem_resp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Identifier field and number of per-identifier queues
  localparam int unsigned IdWidth = 2;
  localparam int unsigned NumIds = 2 ** IdWidth;

  // Message width, identifier included in the low bits
  localparam int unsigned MsgWidth = 16;

  // Shared pool of slots
  localparam int unsigned NumSlots = 16;
  localparam int unsigned SlotAddrWidth = $clog2(NumSlots);

  ////////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [MsgWidth-1:0] msg_t;
  typedef logic [IdWidth-1:0] id_t;
  typedef logic [SlotAddrWidth-1:0] slot_addr_t;

  // One bit per slot
  typedef logic [NumSlots-1:0] slot_mask_t;

  // One bit per identifier queue
  typedef logic [NumIds-1:0] id_mask_t;

  // One extra bit so that a full pool fits
  typedef logic [SlotAddrWidth:0] count_t;

endpackage
